// File: verilog.f
+incdir+include
design/data_region_pkg.sv
design/sp_ram.sv
design/lsu_demux.sv
design/wb_master_bridge.sv
design/ram_arbiter.sv
design/data_region.sv
test/tb_data_region.sv

// File: Makefile
SIM      := verilator
TOP      := tb_data_region
FILELIST := verilog.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

// File: test/tb_data_region.sv
`default_nettype none

`include "data_region_consts.svh"

module tb_data_region;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_FILL = 64;
  localparam int N_TXN = N_FILL + 600;
  localparam int BUS_WORDS = 16;
  // bus waits and outside accesses included, with room to spare
  localparam int LIMIT_CYCLES = N_TXN * 20 + 500;

  typedef struct packed {
    logic                  bus;
    logic                  rd;
    int                    due;
    logic [`DR_DATA_W-1:0] data;
  } exp_t;

  bit                        clk;
  logic                      rst_n;
  logic                      lsu_req_i;
  logic                      lsu_gnt_o;
  data_region_pkg::mem_req_t lsu_txn_i;
  data_region_pkg::mem_rsp_t lsu_rsp_o;
  data_region_pkg::wb_req_t  wbm_o;
  data_region_pkg::wb_rsp_t  wbm_i;
  data_region_pkg::wb_req_t  wbs_i;
  data_region_pkg::wb_rsp_t  wbs_o;

  logic [`DR_DATA_W-1:0] ram_model [0:(1<<`DR_RAM_AW)-1];
  logic [`DR_DATA_W-1:0] bus_mem [logic [`DR_ADDR_W-1:0]];
  exp_t                     rsp_q[$];
  exp_t                     bus_done_q[$];
  data_region_pkg::wb_req_t bus_exp_q[$];

  data_region dut0 (.*);

  always #5 clk = ~clk;

  function automatic logic [`DR_DATA_W-1:0] byte_merge(input logic [`DR_DATA_W-1:0] old,
                                                       input logic [`DR_DATA_W-1:0] wd,
                                                       input logic [`DR_BE_W-1:0] be);
    logic [`DR_DATA_W-1:0] r;
    r = old;
    for (int i = 0; i < `DR_BE_W; i++)
      if (be[i])
        r[8*i +: 8] = wd[8*i +: 8];
    return r;
  endfunction

  function automatic bit is_local(input logic [`DR_ADDR_W-1:0] adr);
    return adr[`DR_ADDR_W-1 -: `DR_PREFIX_W] == `DR_LOCAL_PREFIX;
  endfunction

  // unwritten bus words read back a pattern of their address
  function automatic logic [`DR_DATA_W-1:0] bus_word(input logic [`DR_ADDR_W-1:0] adr);
    if (bus_mem.exists(adr))
      return bus_mem[adr];
    else
      return adr ^ 32'h5ca1_ab1e;
  endfunction

  function automatic data_region_pkg::mem_req_t core_txn(input int fill);
    data_region_pkg::mem_req_t t;
    t.we    = (fill >= 0) ? 1'b1 : 1'($urandom);
    t.be    = (fill >= 0) ? '1 : 4'($urandom);
    t.wdata = $urandom;
    if (fill >= 0)
      t.addr = {`DR_LOCAL_PREFIX, 20'h0} | 32'(fill << 2);
    else if ($urandom % 10 < 6)
      t.addr = {`DR_LOCAL_PREFIX, 20'h0} | 32'(($urandom % N_FILL) << 2);
    else
      t.addr = 32'h4000_0000 | 32'(($urandom % BUS_WORDS) << 2);
    return t;
  endfunction

  // upper address bits are noise the ram port must ignore
  function automatic data_region_pkg::wb_req_t wbs_txn();
    data_region_pkg::wb_req_t t;
    t.cyc = 1'b1;
    t.stb = 1'b1;
    t.we  = 1'($urandom);
    t.adr = {20'($urandom), 10'($urandom % N_FILL), 2'b00};
    t.sel = 4'($urandom);
    t.dat = $urandom;
    return t;
  endfunction

  task automatic fail_now(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "first error, run stopped");
  endtask

  task automatic check_mem_rsp(input data_region_pkg::mem_rsp_t got,
                               input data_region_pkg::mem_rsp_t want,
                               input bit with_data, input string what);
    if (got.rvalid !== want.rvalid || (with_data && got.rdata !== want.rdata))
      fail_now($sformatf("%s: got %0b/%h, expected %0b/%h", what, got.rvalid, got.rdata,
                         want.rvalid, want.rdata));
  endtask

  task automatic check_wb_req(input data_region_pkg::wb_req_t got,
                              input data_region_pkg::wb_req_t want,
                              input bit with_fields, input string what);
    if (got.cyc !== want.cyc || got.stb !== want.stb || (with_fields && got !== want))
      fail_now($sformatf("%s: got %h, expected %h", what, got, want));
  endtask

  task automatic check_wb_rsp(input data_region_pkg::wb_rsp_t got,
                              input data_region_pkg::wb_rsp_t want,
                              input bit with_data, input string what);
    if (got.ack !== want.ack || (with_data && got.dat !== want.dat))
      fail_now($sformatf("%s: got %0b/%h, expected %0b/%h", what, got.ack, got.dat,
                         want.ack, want.dat));
  endtask

  initial
  begin
    #(LIMIT_CYCLES * 10);
    $display("ERROR at %0d ns: run hung, transactions did not complete in time", $time);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    data_region_pkg::mem_req_t nxt_txn;
    data_region_pkg::mem_req_t t;
    data_region_pkg::wb_req_t  nxt_wbs;
    data_region_pkg::wb_req_t  cur_bus;
    data_region_pkg::wb_rsp_t  nxt_wbm;
    exp_t                      e;
    logic [`DR_DATA_W-1:0]     bus_rdata;
    logic [`DR_RAM_AW-1:0]     idx;
    bit                        nxt_req;
    bit                        out_active;
    bit                        bus_seen;
    int                        out_start;
    int                        bus_wait;
    int                        bus_end;
    int                        cycle;
    int                        issued;
    int                        granted;
    int                        rvalids;
    void'($urandom(56811));
    rst_n     <= 1'b0;
    lsu_req_i <= 1'b0;
    lsu_txn_i <= '0;
    wbm_i     <= '0;
    wbs_i     <= '0;
    nxt_txn = '0;
    nxt_wbs = '0;
    nxt_wbm = '0;
    for (int i = 0; i < 6; i++)
    begin
      @(posedge clk);
      rst_n <= (i == 5);
      @(negedge clk);
      check_mem_rsp(lsu_rsp_o, '0, 1'b0, "rvalid around reset");
      check_wb_req(wbm_o, '0, 1'b0, "wishbone master around reset");
      check_wb_rsp(wbs_o, '0, 1'b0, "wishbone slave ack around reset");
    end
    while (issued < N_TXN || nxt_req || rsp_q.size() != 0 || out_active)
    begin
      if (!nxt_req && issued < N_TXN && (issued < N_FILL || $urandom % 4 != 0))
      begin
        nxt_txn = core_txn(issued < N_FILL ? issued : -1);
        nxt_req = 1'b1;
        issued++;
      end
      // outside master joins once the ram words are filled
      if (!out_active && issued > N_FILL && issued < N_TXN && $urandom % 10 < 3)
      begin
        nxt_wbs    = wbs_txn();
        out_active = 1'b1;
        out_start  = cycle + 1;
      end
      @(posedge clk);
      cycle++;
      lsu_req_i <= nxt_req;
      lsu_txn_i <= nxt_txn;
      wbm_i     <= nxt_wbm;
      wbs_i     <= nxt_wbs;
      @(negedge clk);
      if (lsu_rsp_o.rvalid)
      begin
        rvalids++;
        if (rsp_q.size() == 0)
          fail_now("core response with no request outstanding");
        e = rsp_q.pop_front();
        if (e.bus && bus_done_q.size() == 0)
          fail_now("bus response before its wishbone ack");
        else if (e.bus)
          e = bus_done_q.pop_front();
        if (cycle != e.due)
          fail_now($sformatf("response in cycle %0d, expected in cycle %0d", cycle, e.due));
        check_mem_rsp(lsu_rsp_o, {1'b1, e.data}, e.rd, "core response");
      end
      // wishbone slave model with 0 to 3 wait states
      if (wbm_o.stb && cycle == bus_end)
        fail_now("wishbone master kept stb high after ack");
      else if (wbm_o.stb)
      begin
        if (!bus_seen && bus_exp_q.size() == 0)
          fail_now("wishbone cycle with no bus request granted");
        else if (!bus_seen)
        begin
          cur_bus  = bus_exp_q.pop_front();
          bus_seen = 1'b1;
          bus_wait = int'($urandom % 4);
        end
        check_wb_req(wbm_o, cur_bus, 1'b1, "wishbone master request");
        if (wbm_i.ack)
        begin
          if (wbm_o.we)
            bus_mem[wbm_o.adr] = byte_merge(bus_word(wbm_o.adr), wbm_o.dat, wbm_o.sel);
          bus_done_q.push_back('{bus: 1'b1, rd: !wbm_o.we, due: cycle + 1, data: bus_rdata});
          bus_seen = 1'b0;
          bus_end  = cycle + 1;
          nxt_wbm  = '0;
        end
        else if (bus_wait == 0)
        begin
          bus_rdata = bus_word(wbm_o.adr);
          nxt_wbm   = '{ack: 1'b1, dat: bus_rdata};
        end
        else
          bus_wait--;
      end
      idx = wbs_i.adr[`DR_RAM_AW+1:2];
      if (out_active && cycle == out_start)
      begin
        check_wb_rsp(wbs_o, '0, 1'b0, "outside ack in its start cycle");
        if (lsu_req_i && is_local(lsu_txn_i.addr) && lsu_gnt_o)
          fail_now("core granted the ram in the cycle an outside access starts");
      end
      else if (out_active)
      begin
        check_wb_rsp(wbs_o, '{ack: 1'b1, dat: ram_model[idx]}, !wbs_i.we, "outside access");
        if (wbs_i.we)
          ram_model[idx] = byte_merge(ram_model[idx], wbs_i.dat, wbs_i.sel);
        out_active = 1'b0;
        nxt_wbs    = '0;
      end
      else
        check_wb_rsp(wbs_o, '0, 1'b0, "ack with no outside access");
      // grants come after acks, which stand for earlier ram cycles
      if (lsu_req_i && lsu_gnt_o)
      begin
        granted++;
        nxt_req = 1'b0;
        t       = lsu_txn_i;
        idx     = t.addr[`DR_RAM_AW+1:2];
        e       = '{bus: !is_local(t.addr), rd: !t.we, due: cycle + 1, data: ram_model[idx]};
        if (e.bus)
          bus_exp_q.push_back('{cyc: 1'b1, stb: 1'b1, we: t.we, adr: t.addr, sel: t.be,
                                dat: t.wdata});
        else if (t.we)
          ram_model[idx] = byte_merge(ram_model[idx], t.wdata, t.be);
        rsp_q.push_back(e);
      end
    end
    if (rvalids != granted || granted != N_TXN)
    begin
      $display("ERROR at %0d ns: %0d grants but %0d responses", $time, granted, rvalids);
      $display("Result: FAILED");
      $fatal(1, "response count mismatch");
    end
    else
    begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: design/data_region.sv
`default_nettype none

`include "data_region_consts.svh"

module data_region (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           lsu_req_i,
  input  data_region_pkg::mem_req_t     lsu_txn_i,
  output logic                          lsu_gnt_o,
  output data_region_pkg::mem_rsp_t     lsu_rsp_o,
  output data_region_pkg::wb_req_t      wbm_o,
  input  data_region_pkg::wb_rsp_t      wbm_i,
  input  data_region_pkg::wb_req_t      wbs_i,
  output data_region_pkg::wb_rsp_t      wbs_o
);

  logic                      ram_req;
  data_region_pkg::mem_req_t ram_txn;
  logic                      ram_gnt;
  data_region_pkg::mem_rsp_t ram_rsp;
  logic                      bus_req;
  data_region_pkg::mem_req_t bus_txn;
  logic                      bus_gnt;
  data_region_pkg::mem_rsp_t bus_rsp;

  // data ram port
  logic                  mem_en;
  logic                  mem_we;
  logic [`DR_RAM_AW-1:0] mem_addr;
  logic [`DR_BE_W-1:0]   mem_be;
  logic [`DR_DATA_W-1:0] mem_wdata;
  logic [`DR_DATA_W-1:0] mem_rdata;

  lsu_demux demux0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .lsu_req_i (lsu_req_i),
    .lsu_txn_i (lsu_txn_i),
    .lsu_gnt_o (lsu_gnt_o),
    .lsu_rsp_o (lsu_rsp_o),
    .ram_req_o (ram_req),
    .ram_txn_o (ram_txn),
    .ram_gnt_i (ram_gnt),
    .ram_rsp_i (ram_rsp),
    .bus_req_o (bus_req),
    .bus_txn_o (bus_txn),
    .bus_gnt_i (bus_gnt),
    .bus_rsp_i (bus_rsp)
  );

  wb_master_bridge bridge0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req_i (bus_req),
    .bus_txn_i (bus_txn),
    .bus_gnt_o (bus_gnt),
    .bus_rsp_o (bus_rsp),
    .wbm_o     (wbm_o),
    .wbm_i     (wbm_i)
  );

  ram_arbiter arb0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wbs_i       (wbs_i),
    .wbs_o       (wbs_o),
    .core_req_i  (ram_req),
    .core_txn_i  (ram_txn),
    .core_gnt_o  (ram_gnt),
    .core_rsp_o  (ram_rsp),
    .ram_en_o    (mem_en),
    .ram_we_o    (mem_we),
    .ram_addr_o  (mem_addr),
    .ram_be_o    (mem_be),
    .ram_wdata_o (mem_wdata),
    .ram_rdata_i (mem_rdata)
  );

  sp_ram ram0 (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: design/ram_arbiter.sv
`default_nettype none

`include "data_region_consts.svh"

module ram_arbiter (
  input  wire                           clk,
  input  wire                           rst_n,
  input  data_region_pkg::wb_req_t      wbs_i,
  output data_region_pkg::wb_rsp_t      wbs_o,
  input  wire                           core_req_i,
  input  data_region_pkg::mem_req_t     core_txn_i,
  output logic                          core_gnt_o,
  output data_region_pkg::mem_rsp_t     core_rsp_o,
  output logic                          ram_en_o,
  output logic                          ram_we_o,
  output logic [`DR_RAM_AW-1:0]         ram_addr_o,
  output logic [`DR_BE_W-1:0]           ram_be_o,
  output logic [`DR_DATA_W-1:0]         ram_wdata_o,
  input  wire  [`DR_DATA_W-1:0]         ram_rdata_i
);

  logic rd_vld_q;
  logic rd_wbs_q;
  logic ack_pend;
  logic wbs_start;
  logic core_accept;

  // ack cycle still sees stb high, so it must not start a second access
  assign ack_pend  = rd_vld_q && rd_wbs_q;
  assign wbs_start = wbs_i.cyc && wbs_i.stb && !ack_pend;

  // outside master wins the ram
  assign core_gnt_o  = !wbs_start;
  assign core_accept = core_req_i && core_gnt_o;

  always_comb
  begin
    ram_en_o = wbs_start || core_accept;
    if (wbs_start)
    begin
      ram_we_o    = wbs_i.we;
      ram_addr_o  = wbs_i.adr[`DR_RAM_AW+1:2];
      ram_be_o    = wbs_i.sel;
      ram_wdata_o = wbs_i.dat;
    end
    else
    begin
      ram_we_o    = core_txn_i.we;
      ram_addr_o  = core_txn_i.addr[`DR_RAM_AW+1:2];
      ram_be_o    = core_txn_i.be;
      ram_wdata_o = core_txn_i.wdata;
    end
  end

  // who owns the data coming out of the ram next cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_vld_q <= 1'b0;
      rd_wbs_q <= 1'b0;
    end
    else
    begin
      rd_vld_q <= ram_en_o;
      rd_wbs_q <= wbs_start;
    end
  end

  assign wbs_o.ack         = ack_pend;
  assign wbs_o.dat         = ram_rdata_i;
  assign core_rsp_o.rvalid = rd_vld_q && !rd_wbs_q;
  assign core_rsp_o.rdata  = ram_rdata_i;

  // a held stb gets one ack only
  a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wbs_o.ack |=> !wbs_o.ack)
    else $error("wishbone slave ack lasted more than one cycle");

endmodule

`default_nettype wire

// File: design/wb_master_bridge.sv
`default_nettype none

`include "data_region_consts.svh"

module wb_master_bridge (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           bus_req_i,
  input  data_region_pkg::mem_req_t     bus_txn_i,
  output logic                          bus_gnt_o,
  output data_region_pkg::mem_rsp_t     bus_rsp_o,
  output data_region_pkg::wb_req_t      wbm_o,
  input  data_region_pkg::wb_rsp_t      wbm_i
);

  data_region_pkg::mem_req_t txn_q;
  logic                      active_q;
  logic                      rvalid_q;
  logic [`DR_DATA_W-1:0]     rdata_q;
  logic                      accept;
  logic                      done;

  // one cycle at a time, new request only when idle
  assign bus_gnt_o = !active_q;
  assign accept    = bus_req_i && bus_gnt_o;
  assign done      = active_q && wbm_i.ack;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      rvalid_q <= done;
      if (accept)
      begin
        active_q <= 1'b1;
      end
      else if (done)
      begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      txn_q <= bus_txn_i;
    end
    if (done)
    begin
      rdata_q <= wbm_i.dat;
    end
  end

  always_comb
  begin
    wbm_o.cyc = active_q;
    wbm_o.stb = active_q;
    wbm_o.we  = txn_q.we;
    wbm_o.adr = txn_q.addr;
    wbm_o.sel = txn_q.be;
    wbm_o.dat = txn_q.wdata;
  end

  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.rdata  = rdata_q;

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wbm_o.stb && !wbm_i.ack) |=> (wbm_o.stb && $stable(wbm_o)))
    else $error("wishbone master changed a held cycle before ack");

endmodule

`default_nettype wire

// File: design/lsu_demux.sv
`default_nettype none

`include "data_region_consts.svh"

module lsu_demux (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           lsu_req_i,
  input  data_region_pkg::mem_req_t     lsu_txn_i,
  output logic                          lsu_gnt_o,
  output data_region_pkg::mem_rsp_t     lsu_rsp_o,
  output logic                          ram_req_o,
  output data_region_pkg::mem_req_t     ram_txn_o,
  input  wire                           ram_gnt_i,
  input  data_region_pkg::mem_rsp_t     ram_rsp_i,
  output logic                          bus_req_o,
  output data_region_pkg::mem_req_t     bus_txn_o,
  input  wire                           bus_gnt_i,
  input  data_region_pkg::mem_rsp_t     bus_rsp_i
);

  typedef enum logic {TGT_RAM, TGT_BUS} tgt_e;

  tgt_e       cur_tgt_q;
  tgt_e       req_tgt;
  logic [1:0] cnt_q;
  logic       is_local;
  logic       rsp_vld;
  logic       drained;
  logic       full;
  logic       allow;

  assign is_local = (lsu_txn_i.addr[`DR_ADDR_W-1 -: `DR_PREFIX_W] == `DR_LOCAL_PREFIX);
  assign req_tgt  = is_local ? TGT_RAM : TGT_BUS;

  // responses come back from whichever target was granted last
  assign lsu_rsp_o = (cur_tgt_q == TGT_BUS) ? bus_rsp_i : ram_rsp_i;
  assign rsp_vld   = lsu_rsp_o.rvalid;

  // switching target only once the last response is back or returning now
  assign drained = (cnt_q == 2'd0) || ((cnt_q == 2'd1) && rsp_vld);
  assign full    = (cnt_q == 2'd3) && !rsp_vld;
  assign allow   = ((req_tgt == cur_tgt_q) || drained) && !full;

  assign ram_req_o = lsu_req_i && allow && is_local;
  assign bus_req_o = lsu_req_i && allow && !is_local;
  assign ram_txn_o = lsu_txn_i;
  assign bus_txn_o = lsu_txn_i;

  assign lsu_gnt_o = is_local ? (ram_req_o && ram_gnt_i) : (bus_req_o && bus_gnt_i);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cur_tgt_q <= TGT_RAM;
      cnt_q     <= 2'd0;
    end
    else
    begin
      if (lsu_gnt_o)
      begin
        cur_tgt_q <= req_tgt;
      end
      case ({lsu_gnt_o, rsp_vld})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // ordering rule above keeps the two targets from answering together
  a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_rsp_i.rvalid && bus_rsp_i.rvalid))
    else $error("ram and bus responses in the same cycle");

endmodule

`default_nettype wire

// File: design/sp_ram.sv
`default_nettype none

`include "data_region_consts.svh"

module sp_ram (
  input  wire                    clk,
  input  wire                    en_i,
  input  wire                    we_i,
  input  wire  [`DR_RAM_AW-1:0]  addr_i,
  input  wire  [`DR_BE_W-1:0]    be_i,
  input  wire  [`DR_DATA_W-1:0]  wdata_i,
  output logic [`DR_DATA_W-1:0]  rdata_o
);

  logic [`DR_DATA_W-1:0] mem [0:(1<<`DR_RAM_AW)-1];

  // read returns the old word on a write
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < `DR_BE_W; i++)
        begin
          if (be_i[i])
          begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: design/data_region_pkg.sv
`default_nettype none

`include "data_region_consts.svh"

package data_region_pkg;

  // load/store request from the core side
  typedef struct packed {
    logic [`DR_ADDR_W-1:0] addr;
    logic                  we;
    logic [`DR_BE_W-1:0]   be;
    logic [`DR_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  rvalid;
    logic [`DR_DATA_W-1:0] rdata;
  } mem_rsp_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`DR_ADDR_W-1:0] adr;
    logic [`DR_BE_W-1:0]   sel;
    logic [`DR_DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic [`DR_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: include/data_region_consts.svh
`ifndef DATA_REGION_CONSTS_SVH
`define DATA_REGION_CONSTS_SVH

// core and bus widths
`define DR_ADDR_W 32
`define DR_DATA_W 32
`define DR_BE_W 4

// data ram holds 2**DR_RAM_AW words
`define DR_RAM_AW 10

// upper address bits that select the local data ram
`define DR_PREFIX_W 12
`define DR_LOCAL_PREFIX 12'h001

`endif
